// ==== verilog/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

   // cache line geometry
   localparam int LINE_BYTES    = 16;
   localparam int LINE_OFS_BITS = 4;

   typedef logic [31:0] vaddr_t;
   typedef logic [31:0] paddr_t;
   typedef logic [63:0] data_t;

   // 0: 1 byte, 1: 2 bytes, 2: 4 bytes, 3: 8 bytes
   typedef logic [1:0] size_code_t;
   typedef logic [3:0] byte_cnt_t;

   typedef struct packed {
      vaddr_t     addr;
      size_code_t size;
   } lsu_req_t;

   typedef struct packed {
      data_t data;
      logic  fault;
   } lsu_rsp_t;

   typedef struct packed {
      paddr_t    addr;
      byte_cnt_t bytes;
   } dcache_req_t;

   // both cache accesses of one read, worked out before acceptance
   typedef struct packed {
      paddr_t    first_addr;
      byte_cnt_t first_bytes;
      paddr_t    second_addr;
      byte_cnt_t second_bytes;
      logic      split;
      logic      fault;
   } access_plan_t;

   function automatic byte_cnt_t size_to_bytes(input size_code_t size);
      return byte_cnt_t'(1) << size;
   endfunction

endpackage

`default_nettype wire

// ==== verilog/mmu_pkg.sv ====
`default_nettype none

package mmu_pkg;

   localparam int PAGE_OFS_BITS = 12;
   localparam int TLB_ENTRIES   = 8;

   typedef logic [2:0]  tlb_index_t;
   typedef logic [19:0] vpn_t;
   typedef logic [19:0] ppn_t;

   typedef struct packed {
      ppn_t ppn;
      logic valid;
      logic present;
   } tlb_entry_t;

   // hit only for a valid, present, matching entry
   typedef struct packed {
      logic hit;
      ppn_t ppn;
   } tlb_lookup_t;

   typedef struct packed {
      logic       en;
      tlb_index_t index;
      vpn_t       vpn;
      tlb_entry_t entry;
   } tlb_write_t;

endpackage

`default_nettype wire

// ==== verilog/tlb_table.sv ====
`default_nettype none
`timescale 1ns/1ns

module tlb_table (
   input  wire                      clk,
   input  wire                      rst_n,
   input  wire mmu_pkg::tlb_write_t tlb_wr,
   input  wire mmu_pkg::vpn_t       vpn_a,
   input  wire mmu_pkg::vpn_t       vpn_b,
   output mmu_pkg::tlb_lookup_t     lookup_a,
   output mmu_pkg::tlb_lookup_t     lookup_b
);

   logic [mmu_pkg::TLB_ENTRIES-1:0] valid_q;
   logic [mmu_pkg::TLB_ENTRIES-1:0] present_q;
   mmu_pkg::vpn_t                   tag_q [mmu_pkg::TLB_ENTRIES];
   mmu_pkg::ppn_t                   ppn_q [mmu_pkg::TLB_ENTRIES];

   // entries come up invalid
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         valid_q <= '0;
      end
      else if (tlb_wr.en)
      begin
         valid_q[tlb_wr.index] <= tlb_wr.entry.valid;
      end
   end

   always_ff @(posedge clk)
   begin
      if (tlb_wr.en)
      begin
         tag_q[tlb_wr.index]     <= tlb_wr.vpn;
         ppn_q[tlb_wr.index]     <= tlb_wr.entry.ppn;
         present_q[tlb_wr.index] <= tlb_wr.entry.present;
      end
   end

   // walk down so the lowest matching index wins
   function automatic mmu_pkg::tlb_lookup_t search(input mmu_pkg::vpn_t vpn);
      mmu_pkg::tlb_lookup_t res;
      res = '0;
      for (int i = mmu_pkg::TLB_ENTRIES - 1; i >= 0; i--)
      begin
         if (valid_q[i] && present_q[i] && (tag_q[i] == vpn))
         begin
            res.hit = 1'b1;
            res.ppn = ppn_q[i];
         end
      end
      return res;
   endfunction

   // both ports follow the table contents as well as the vpns
   always_comb
   begin
      lookup_a = search(vpn_a);
      lookup_b = search(vpn_b);
   end

   a_wr_index_in_range: assert property (@(posedge clk) disable iff (!rst_n)
      tlb_wr.en |-> !$isunknown(tlb_wr.index) &&
                    (int'(tlb_wr.index) < mmu_pkg::TLB_ENTRIES));

endmodule

`default_nettype wire

// ==== verilog/lsu_translate.sv ====
`default_nettype none
`timescale 1ns/1ns

module lsu_translate (
   input  wire lsu_pkg::lsu_req_t    req,
   output mmu_pkg::vpn_t             vpn_a,
   output mmu_pkg::vpn_t             vpn_b,
   input  wire mmu_pkg::tlb_lookup_t lookup_a,
   input  wire mmu_pkg::tlb_lookup_t lookup_b,
   output lsu_pkg::access_plan_t     plan
);

   localparam int LOB = lsu_pkg::LINE_OFS_BITS;
   localparam int POB = mmu_pkg::PAGE_OFS_BITS;

   lsu_pkg::byte_cnt_t n;
   logic [LOB-1:0]     off;
   logic [LOB:0]       end_ofs;
   logic [LOB:0]       first_room;
   lsu_pkg::vaddr_t    next_line;
   logic               split;
   logic               cross_page;

   assign n   = lsu_pkg::size_to_bytes(req.size);
   assign off = req.addr[LOB-1:0];

   // one past the last byte, relative to the line start
   assign end_ofs    = {1'b0, off} + {1'b0, n};
   assign first_room = (LOB+1)'(lsu_pkg::LINE_BYTES) - {1'b0, off};
   assign split      = end_ofs > (LOB+1)'(lsu_pkg::LINE_BYTES);

   // linear address of the following line
   assign next_line = {req.addr[31:LOB] + 1'b1, {LOB{1'b0}}};

   assign vpn_a = req.addr[31:POB];
   assign vpn_b = next_line[31:POB];

   // same page means vpn_b equals vpn_a, so lookup_b is right in both cases
   assign cross_page = split && (vpn_b != vpn_a);

   always_comb
   begin
      plan.first_addr  = {lookup_a.ppn, req.addr[POB-1:0]};
      plan.second_addr = {lookup_b.ppn, next_line[POB-1:0]};
      plan.split       = split;
      if (split)
      begin
         plan.first_bytes  = first_room[LOB-1:0];
         // end_ofs is 17..23 here, low bits give the remainder
         plan.second_bytes = end_ofs[LOB-1:0];
      end
      else
      begin
         plan.first_bytes  = n;
         plan.second_bytes = '0;
      end
      plan.fault = !lookup_a.hit || (cross_page && !lookup_b.hit);
   end

endmodule

`default_nettype wire

// ==== verilog/lsu_merge.sv ====
`default_nettype none
`timescale 1ns/1ns

module lsu_merge (
   input  wire lsu_pkg::data_t     first_data,
   input  wire lsu_pkg::data_t     second_data,
   input  wire lsu_pkg::byte_cnt_t first_bytes,
   input  wire lsu_pkg::byte_cnt_t total_bytes,
   input  wire                     split,
   output lsu_pkg::data_t          merged
);

   lsu_pkg::data_t combined;

   // ones over the low cnt bytes
   function automatic lsu_pkg::data_t byte_mask(input lsu_pkg::byte_cnt_t cnt);
      if (cnt >= 4'd8)
      begin
         return '1;
      end
      return (lsu_pkg::data_t'(1) << {cnt, 3'b000}) - 1'b1;
   endfunction

   // second access lands just above the first one's bytes
   assign combined = split ?
      ((first_data & byte_mask(first_bytes)) | (second_data << {first_bytes, 3'b000})) :
      first_data;

   assign merged = combined & byte_mask(total_bytes);

endmodule

`default_nettype wire

// ==== verilog/lsu_sequencer.sv ====
`default_nettype none
`timescale 1ns/1ns

module lsu_sequencer (
   input  wire                        clk,
   input  wire                        rst_n,
   input  wire                        req_valid,
   output logic                       req_ready,
   input  wire lsu_pkg::size_code_t   size,
   input  wire lsu_pkg::access_plan_t plan,
   output logic                       rsp_valid,
   output lsu_pkg::lsu_rsp_t          rsp,
   output logic                       dcache_req_valid,
   output lsu_pkg::dcache_req_t       dcache_req,
   input  wire                        dcache_ready,
   input  wire lsu_pkg::data_t        dcache_rd_data
);

   typedef enum logic [1:0] {
      S_IDLE,
      S_FIRST,
      S_SECOND,
      S_RESPOND
   } state_t;

   state_t                state_q;
   state_t                state_d;
   lsu_pkg::access_plan_t plan_q;
   lsu_pkg::size_code_t   size_q;
   lsu_pkg::data_t        first_data_q;
   lsu_pkg::data_t        second_data_q;
   lsu_pkg::data_t        merged;
   logic                  accept;

   assign req_ready        = (state_q == S_IDLE);
   assign accept           = req_valid && req_ready;
   assign dcache_req_valid = (state_q == S_FIRST) || (state_q == S_SECOND);
   assign rsp_valid        = (state_q == S_RESPOND);

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         S_IDLE:
         begin
            // a fault skips the cache and answers right away
            if (accept)
            begin
               state_d = plan.fault ? S_RESPOND : S_FIRST;
            end
         end
         S_FIRST:
         begin
            if (dcache_ready)
            begin
               state_d = plan_q.split ? S_SECOND : S_RESPOND;
            end
         end
         S_SECOND:
         begin
            if (dcache_ready)
            begin
               state_d = S_RESPOND;
            end
         end
         default:
         begin
            state_d = S_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_q <= S_IDLE;
      end
      else
      begin
         state_q <= state_d;
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         plan_q <= plan;
         size_q <= size;
      end
      if ((state_q == S_FIRST) && dcache_ready)
      begin
         first_data_q <= dcache_rd_data;
      end
      if ((state_q == S_SECOND) && dcache_ready)
      begin
         second_data_q <= dcache_rd_data;
      end
   end

   always_comb
   begin
      if (state_q == S_SECOND)
      begin
         dcache_req.addr  = plan_q.second_addr;
         dcache_req.bytes = plan_q.second_bytes;
      end
      else
      begin
         dcache_req.addr  = plan_q.first_addr;
         dcache_req.bytes = plan_q.first_bytes;
      end
   end

   lsu_merge u_merge (
      .first_data  (first_data_q),
      .second_data (second_data_q),
      .first_bytes (plan_q.first_bytes),
      .total_bytes (lsu_pkg::size_to_bytes(size_q)),
      .split       (plan_q.split),
      .merged      (merged)
   );

   assign rsp.data  = plan_q.fault ? '0 : merged;
   assign rsp.fault = plan_q.fault;

   // cache sees a held request until it takes it
   a_dcache_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
      dcache_req_valid && !dcache_ready |=> dcache_req_valid && $stable(dcache_req));

   a_rsp_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      rsp_valid |=> !rsp_valid);

   a_no_accept_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
      dcache_req_valid |-> !req_ready);

endmodule

`default_nettype wire

// ==== verilog/lsu_top.sv ====
`default_nettype none
`timescale 1ns/1ns

module lsu_top (
   input  wire                      clk,
   input  wire                      rst_n,
   input  wire                      req_valid,
   input  wire lsu_pkg::lsu_req_t   req,
   output logic                     req_ready,
   output logic                     rsp_valid,
   output lsu_pkg::lsu_rsp_t        rsp,
   input  wire mmu_pkg::tlb_write_t tlb_wr,
   output logic                     dcache_req_valid,
   output lsu_pkg::dcache_req_t     dcache_req,
   input  wire                      dcache_ready,
   input  wire lsu_pkg::data_t      dcache_rd_data
);

   mmu_pkg::vpn_t         vpn_a;
   mmu_pkg::vpn_t         vpn_b;
   mmu_pkg::tlb_lookup_t  lookup_a;
   mmu_pkg::tlb_lookup_t  lookup_b;
   lsu_pkg::access_plan_t plan;

   tlb_table u_tlb_table (
      .clk      (clk),
      .rst_n    (rst_n),
      .tlb_wr   (tlb_wr),
      .vpn_a    (vpn_a),
      .vpn_b    (vpn_b),
      .lookup_a (lookup_a),
      .lookup_b (lookup_b)
   );

   // plan is built from the request as presented, before acceptance
   lsu_translate u_translate (
      .req      (req),
      .vpn_a    (vpn_a),
      .vpn_b    (vpn_b),
      .lookup_a (lookup_a),
      .lookup_b (lookup_b),
      .plan     (plan)
   );

   lsu_sequencer u_sequencer (
      .clk              (clk),
      .rst_n            (rst_n),
      .req_valid        (req_valid),
      .req_ready        (req_ready),
      .size             (req.size),
      .plan             (plan),
      .rsp_valid        (rsp_valid),
      .rsp              (rsp),
      .dcache_req_valid (dcache_req_valid),
      .dcache_req       (dcache_req),
      .dcache_ready     (dcache_ready),
      .dcache_rd_data   (dcache_rd_data)
   );

endmodule

`default_nettype wire

// ==== dv/tb_clock.sv ====
`default_nettype none
`timescale 1ns/1ns

module tb_clock (
   output logic clk,
   output logic rst_n
);

   // 40 ns period
   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // low for the first three rising edges
   initial
   begin
      rst_n = 1'b0;
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
   end

endmodule

`default_nettype wire

// ==== dv/lsu_tb.sv ====
`default_nettype none
`timescale 1ns/1ns

module lsu_tb;

   localparam int DIRECTED_READS  = 40;
   localparam int RANDOM_READS    = 200;
   localparam int CYCLES_PER_READ = 20;
   localparam int MARGIN_CYCLES   = 200;

   logic                  clk;
   logic                  rst_n;
   logic                  req_valid;
   lsu_pkg::lsu_req_t     req;
   logic                  req_ready;
   logic                  rsp_valid;
   lsu_pkg::lsu_rsp_t     rsp;
   mmu_pkg::tlb_write_t   tlb_wr;
   logic                  dcache_req_valid;
   lsu_pkg::dcache_req_t  dcache_req;
   logic                  dcache_ready;
   lsu_pkg::data_t        dcache_rd_data;

   // shadow copy of the TLB
   mmu_pkg::vpn_t         shadow_tag [mmu_pkg::TLB_ENTRIES];
   mmu_pkg::tlb_entry_t   shadow_entry [mmu_pkg::TLB_ENTRIES];

   // expectation for the read in flight
   lsu_pkg::lsu_rsp_t     exp_rsp;
   lsu_pkg::dcache_req_t  exp_acc0;
   lsu_pkg::dcache_req_t  exp_acc1;
   int                    exp_accesses;
   string                 exp_name;
   lsu_pkg::dcache_req_t  access_q [$];

   string                 test_name;
   int                    test_reads;
   int                    test_start_errors;
   int                    tests_run;
   int                    tests_failed;
   int                    check_count;
   int                    error_count;

   tb_clock u_clock (
      .clk   (clk),
      .rst_n (rst_n)
   );

   lsu_top lsu_top_inst (
      .clk              (clk),
      .rst_n            (rst_n),
      .req_valid        (req_valid),
      .req              (req),
      .req_ready        (req_ready),
      .rsp_valid        (rsp_valid),
      .rsp              (rsp),
      .tlb_wr           (tlb_wr),
      .dcache_req_valid (dcache_req_valid),
      .dcache_req       (dcache_req),
      .dcache_ready     (dcache_ready),
      .dcache_rd_data   (dcache_rd_data)
   );

   // lowest matching index wins
   function automatic mmu_pkg::tlb_lookup_t shadow_lookup(input mmu_pkg::vpn_t vpn);
      mmu_pkg::tlb_lookup_t res;
      res = '0;
      for (int i = 0; i < mmu_pkg::TLB_ENTRIES; i++)
      begin
         if (!res.hit && shadow_entry[i].valid && shadow_entry[i].present &&
             (shadow_tag[i] == vpn))
         begin
            res.hit = 1'b1;
            res.ppn = shadow_entry[i].ppn;
         end
      end
      return res;
   endfunction

   // expected response, cache accesses and access count of one read
   function automatic lsu_pkg::lsu_rsp_t expected_rsp(
      input  lsu_pkg::lsu_req_t    r,
      output lsu_pkg::dcache_req_t acc0,
      output lsu_pkg::dcache_req_t acc1,
      output int                   accesses
   );
      lsu_pkg::lsu_rsp_t    res;
      mmu_pkg::tlb_lookup_t la;
      mmu_pkg::tlb_lookup_t lb;
      lsu_pkg::vaddr_t      nxt;
      lsu_pkg::paddr_t      pa;
      int                   n;
      int                   off;
      int                   first_n;
      logic                 split;
      res        = '0;
      n          = 1 << r.size;
      off        = int'(r.addr[3:0]);
      split      = (off + n) > lsu_pkg::LINE_BYTES;
      first_n    = split ? lsu_pkg::LINE_BYTES - off : n;
      nxt        = {r.addr[31:4], 4'h0} + 32'd16;
      la         = shadow_lookup(r.addr[31:12]);
      lb         = shadow_lookup(nxt[31:12]);
      acc0.addr  = {la.ppn, r.addr[11:0]};
      acc0.bytes = lsu_pkg::byte_cnt_t'(first_n);
      acc1.addr  = {lb.ppn, nxt[11:0]};
      acc1.bytes = lsu_pkg::byte_cnt_t'(n - first_n);
      accesses   = split ? 2 : 1;
      if (!la.hit || (split && (nxt[31:12] != r.addr[31:12]) && !lb.hit))
      begin
         res.fault = 1'b1;
         accesses  = 0;
         return res;
      end
      for (int i = 0; i < n; i++)
      begin
         pa = (i < first_n) ? acc0.addr + i : acc1.addr + (i - first_n);
         res.data[i*8 +: 8] = pa[7:0] ^ 8'h5A;
      end
      return res;
   endfunction

   // requested bytes from the address pattern, junk above the count
   function automatic lsu_pkg::data_t cache_data(input lsu_pkg::dcache_req_t creq);
      lsu_pkg::data_t  d;
      lsu_pkg::paddr_t pa;
      for (int i = 0; i < 8; i++)
      begin
         pa = creq.addr + i;
         if (i < int'(creq.bytes))
         begin
            d[i*8 +: 8] = pa[7:0] ^ 8'h5A;
         end
         else
         begin
            d[i*8 +: 8] = 8'($urandom);
         end
      end
      return d;
   endfunction

   task automatic check_data(input string name, input lsu_pkg::data_t exp,
                             input lsu_pkg::data_t act);
      check_count++;
      if (exp !== act)
      begin
         error_count++;
         $display("FAILED %s: data expected %016h actual %016h", name, exp, act);
      end
   endtask

   task automatic check_fault(input string name, input logic exp, input logic act);
      check_count++;
      if (exp !== act)
      begin
         error_count++;
         $display("FAILED %s: fault expected %0b actual %0b", name, exp, act);
      end
   endtask

   task automatic check_addr(input string name, input lsu_pkg::paddr_t exp,
                             input lsu_pkg::paddr_t act);
      check_count++;
      if (exp !== act)
      begin
         error_count++;
         $display("FAILED %s: cache address expected %08h actual %08h", name, exp, act);
      end
   endtask

   task automatic check_bytes(input string name, input lsu_pkg::byte_cnt_t exp,
                              input lsu_pkg::byte_cnt_t act);
      check_count++;
      if (exp !== act)
      begin
         error_count++;
         $display("FAILED %s: cache byte count expected %0d actual %0d", name, exp, act);
      end
   endtask

   task automatic write_tlb(input mmu_pkg::tlb_index_t index, input mmu_pkg::vpn_t vpn,
                            input mmu_pkg::ppn_t ppn, input logic valid, input logic present);
      mmu_pkg::tlb_write_t w;
      w.en            = 1'b1;
      w.index         = index;
      w.vpn           = vpn;
      w.entry.ppn     = ppn;
      w.entry.valid   = valid;
      w.entry.present = present;
      tlb_wr <= w;
      shadow_tag[index]   = vpn;
      shadow_entry[index] = w.entry;
      @(posedge clk);
      tlb_wr <= '0;
   endtask

   // one read from request to response
   task automatic issue_read(input lsu_pkg::vaddr_t addr, input lsu_pkg::size_code_t size);
      lsu_pkg::lsu_req_t r;
      r.addr   = addr;
      r.size   = size;
      exp_rsp  = expected_rsp(r, exp_acc0, exp_acc1, exp_accesses);
      exp_name = $sformatf("%s read %0d at %08h size %0d", test_name, test_reads, addr, size);
      test_reads++;
      req_valid <= 1'b1;
      req       <= r;
      @(posedge clk);
      if (!req_ready)
      begin
         error_count++;
         $display("%s: req_ready was low when the request was presented", exp_name);
      end
      req_valid <= 1'b0;
      do
         @(posedge clk);
      while (!rsp_valid);
      // lets the compare process finish with this response
      @(posedge clk);
   endtask

   task automatic start_test(input string name);
      test_name         = name;
      test_reads        = 0;
      test_start_errors = error_count;
   endtask

   task automatic end_test();
      tests_run++;
      if (error_count == test_start_errors)
      begin
         $display("test %s: PASS, %0d reads", test_name, test_reads);
      end
      else
      begin
         tests_failed++;
         $display("test %s: FAIL, %0d errors in %0d reads", test_name,
                  error_count - test_start_errors, test_reads);
      end
   endtask

   // data cache with a 0 to 3 cycle wait
   initial
   begin
      int wait_cycles;
      forever
      begin
         @(posedge clk);
         if (rst_n && dcache_req_valid)
         begin
            access_q.push_back(dcache_req);
            wait_cycles = $urandom_range(3, 0);
            repeat (wait_cycles) @(posedge clk);
            dcache_ready   <= 1'b1;
            dcache_rd_data <= cache_data(dcache_req);
            @(posedge clk);
            dcache_ready   <= 1'b0;
            dcache_rd_data <= '0;
         end
      end
   end

   // compare each response with the expectation
   always @(posedge clk)
   begin
      if (rst_n && rsp_valid)
      begin
         check_fault(exp_name, exp_rsp.fault, rsp.fault);
         check_data(exp_name, exp_rsp.data, rsp.data);
         if (access_q.size() != exp_accesses)
         begin
            error_count++;
            $display("%s: saw %0d cache accesses where %0d were expected",
                     exp_name, access_q.size(), exp_accesses);
         end
         else
         begin
            if (exp_accesses > 0)
            begin
               check_addr(exp_name, exp_acc0.addr, access_q[0].addr);
               check_bytes(exp_name, exp_acc0.bytes, access_q[0].bytes);
            end
            if (exp_accesses > 1)
            begin
               check_addr(exp_name, exp_acc1.addr, access_q[1].addr);
               check_bytes(exp_name, exp_acc1.bytes, access_q[1].bytes);
            end
         end
         access_q.delete();
      end
   end

   initial
   begin
      repeat ((DIRECTED_READS + RANDOM_READS) * CYCLES_PER_READ + MARGIN_CYCLES) @(posedge clk);
      $display("watchdog expired before all reads completed");
      $display("Some tests failed");
      $finish;
   end

   initial
   begin
      void'($urandom(32'he9ff651c));
      req_valid      = 1'b0;
      req            = '0;
      tlb_wr         = '0;
      dcache_ready   = 1'b0;
      dcache_rd_data = '0;
      tests_run      = 0;
      tests_failed   = 0;
      check_count    = 0;
      error_count    = 0;
      for (int i = 0; i < mmu_pkg::TLB_ENTRIES; i++)
      begin
         shadow_tag[i]   = '0;
         shadow_entry[i] = '0;
      end
      wait (rst_n);
      @(posedge clk);
      if (!req_ready || rsp_valid || dcache_req_valid)
      begin
         error_count++;
         $display("outputs after reset are not idle");
      end

      // page 3 not present, pages 0, 5 and 6 unmapped, index 3 shadows index 4
      write_tlb(3'd0, 20'h00001, 20'h00A37, 1'b1, 1'b1);
      write_tlb(3'd1, 20'h00002, 20'h3C051, 1'b1, 1'b1);
      write_tlb(3'd2, 20'h00003, 20'h00777, 1'b1, 1'b0);
      write_tlb(3'd3, 20'h00004, 20'h12345, 1'b1, 1'b1);
      write_tlb(3'd4, 20'h00004, 20'h55555, 1'b1, 1'b1);

      start_test("aligned");
      for (int s = 0; s < 4; s++)
      begin
         issue_read(32'h0000_1000 + 32'h20 * s, lsu_pkg::size_code_t'(s));
         issue_read(32'h0000_2048, lsu_pkg::size_code_t'(s));
         issue_read(32'h0000_4FF8, lsu_pkg::size_code_t'(s));
      end
      end_test();

      start_test("line_cross");
      issue_read(32'h0000_100F, 2'd1);
      issue_read(32'h0000_100E, 2'd2);
      issue_read(32'h0000_100D, 2'd2);
      issue_read(32'h0000_1009, 2'd3);
      issue_read(32'h0000_100F, 2'd3);
      issue_read(32'h0000_205C, 2'd3);
      issue_read(32'h0000_4A3E, 2'd2);
      end_test();

      start_test("page_cross");
      issue_read(32'h0000_1FFC, 2'd3);
      issue_read(32'h0000_1FFF, 2'd1);
      issue_read(32'h0000_1FF9, 2'd3);
      issue_read(32'h0000_1FFE, 2'd2);
      end_test();

      start_test("fault");
      issue_read(32'h0000_0010, 2'd0);
      issue_read(32'h0000_5000, 2'd2);
      issue_read(32'h0000_3010, 2'd3);
      issue_read(32'h0000_2FFC, 2'd3);
      issue_read(32'h0000_4FFE, 2'd2);
      end_test();

      start_test("tlb_rewrite");
      write_tlb(3'd1, 20'h00002, 20'h0BEEF, 1'b1, 1'b1);
      issue_read(32'h0000_2008, 2'd3);
      issue_read(32'h0000_1FFA, 2'd3);
      write_tlb(3'd1, 20'h00002, 20'h0BEEF, 1'b0, 1'b1);
      issue_read(32'h0000_2008, 2'd3);
      write_tlb(3'd5, 20'h00002, 20'h7A0F1, 1'b1, 1'b1);
      issue_read(32'h0000_2008, 2'd3);
      write_tlb(3'd1, 20'h00002, 20'h3C051, 1'b1, 1'b1);
      issue_read(32'h0000_2008, 2'd3);
      end_test();

      start_test("random");
      for (int k = 0; k < RANDOM_READS; k++)
      begin
         issue_read({12'h000, 8'($urandom_range(6, 0)), 12'($urandom)},
                    lsu_pkg::size_code_t'($urandom_range(3, 0)));
      end
      end_test();

      $display("%0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
               tests_run, tests_run - tests_failed, tests_failed, check_count, error_count);
      if (error_count == 0)
      begin
         $display("All tests passed");
      end
      else
      begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== files.f ====
verilog/lsu_pkg.sv
verilog/mmu_pkg.sv
verilog/tlb_table.sv
verilog/lsu_translate.sv
verilog/lsu_merge.sv
verilog/lsu_sequencer.sv
verilog/lsu_top.sv
dv/tb_clock.sv
dv/lsu_tb.sv

// ==== Bender.yml ====
package:
  name: lsu_read

sources:
  - verilog/lsu_pkg.sv
  - verilog/mmu_pkg.sv
  - verilog/tlb_table.sv
  - verilog/lsu_translate.sv
  - verilog/lsu_merge.sv
  - verilog/lsu_sequencer.sv
  - verilog/lsu_top.sv
  - target: test
    files:
      - dv/tb_clock.sv
      - dv/lsu_tb.sv
